//--- src/vc_pkg.sv
package vc_pkg;

    ////////////////////
    // Sizing
    ////////////////////

    localparam int DATA_WIDTH = 32;
    localparam int REG_NUM    = 32;
    localparam int LANES      = 4;
    localparam int VLEN       = 512;
    localparam int ELEMS      = VLEN / (DATA_WIDTH * LANES);
    localparam int VLMAX      = LANES * ELEMS;
    localparam int IQ_DEPTH   = 8;
    localparam int IQ_PTR_B   = $clog2(IQ_DEPTH);
    localparam int ADDR_B     = $clog2(REG_NUM);
    localparam int ELEM_B     = $clog2(ELEMS);
    localparam int LANE_B     = $clog2(LANES);
    // One extra bit so an all-ones word still fits
    localparam int SBIT_CNT_B = $clog2(DATA_WIDTH) + 1;

    ////////////////////
    // Instruction format
    ////////////////////

    typedef logic [DATA_WIDTH-1:0] word_t;

    typedef struct packed {
        logic [5:0]        funct6;
        logic              vm;
        logic [ADDR_B-1:0] vs2;
        logic [ADDR_B-1:0] vs1_rs1_imm;
        logic [2:0]        funct3;
        logic [ADDR_B-1:0] vd;
        logic [6:0]        opcode;
    } vinstr_t;

    typedef enum logic [5:0] {
        VADD    = 6'b000000,
        VSUB    = 6'b000010,
        VAND    = 6'b001001,
        VOR     = 6'b001010,
        VXOR    = 6'b001011,
        VMV_X_S = 6'b010000,
        VID     = 6'b010100
    } funct6_e;

    typedef enum logic [2:0] {
        OPIVV = 3'b000,
        OPMVV = 3'b010,
        OPIVI = 3'b011,
        OPIVX = 3'b100
    } funct3_e;

    localparam logic [6:0] VARITH = 7'b1010111;

endpackage

//--- src/vc_fifo.sv
`timescale 1ns/100ps

module vc_fifo import vc_pkg::*; #(
    parameter type T = word_t
) (
    input  logic clk_i,
    input  logic resetn_i,
    input  logic push_i,
    input  logic pop_i,
    input  T     data_i,
    output T     data_o,
    output logic empty_o,
    output logic full_o
);

    T                    mem [IQ_DEPTH];
    logic [IQ_PTR_B-1:0] wr_ptr_q;
    logic [IQ_PTR_B-1:0] rd_ptr_q;
    logic [IQ_PTR_B:0]   count_q;
    logic                do_push;
    logic                do_pop;

    assign full_o  = (count_q == (IQ_PTR_B+1)'(IQ_DEPTH));
    assign empty_o = (count_q == '0);

    // Requests that would overflow or underflow are dropped here
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // Oldest entry is always visible
    assign data_o = mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i or negedge resetn_i) begin
        if (!resetn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

//--- src/lane_vrf.sv
`timescale 1ns/100ps

module lane_vrf import vc_pkg::*; (
    input  logic              clk_i,
    input  logic              resetn_i,
    input  logic              we_i,
    input  logic [ADDR_B-1:0] waddr_i,
    input  logic [ADDR_B-1:0] raddr_a_i,
    input  logic [ADDR_B-1:0] raddr_b_i,
    input  logic [ELEM_B-1:0] wslot_i,
    input  logic [ELEM_B-1:0] rslot_i,
    input  word_t             wdata_i,
    output word_t             rdata_a_o,
    output word_t             rdata_b_o
);

    // One slice of every vector register
    word_t regs [REG_NUM][ELEMS];

    always_ff @(posedge clk_i or negedge resetn_i) begin
        if (!resetn_i) begin
            for (int r = 0; r < REG_NUM; r++) begin
                for (int e = 0; e < ELEMS; e++) begin
                    regs[r][e] <= '0;
                end
            end
        end else if (we_i) begin
            regs[waddr_i][wslot_i] <= wdata_i;
        end
    end

    assign rdata_a_o = regs[raddr_a_i][rslot_i];
    assign rdata_b_o = regs[raddr_b_i][rslot_i];

endmodule

//--- src/lane.sv
`timescale 1ns/100ps

module lane import vc_pkg::*; #(
    parameter int LANE_ID = 0
) (
    input  logic                  clk_i,
    input  logic                  resetn_i,
    input  logic                  issue_i,
    input  vinstr_t               instr_i,
    input  word_t                 scalar_i,
    output logic                  ready_o,
    output word_t                 elem_o,
    output logic [SBIT_CNT_B-1:0] sbit_cnt_o
);

    logic              busy_q;
    logic [ELEM_B-1:0] slot_q;
    logic [ELEM_B-1:0] rd_slot;
    logic              last_slot;
    logic              is_arith;
    logic              is_vid;
    logic              is_vmv;
    logic              we;
    word_t             vs1_data;
    word_t             vs2_data;
    word_t             op_b;
    word_t             alu_res;
    word_t             vid_val;
    word_t             wdata;

    function automatic logic [SBIT_CNT_B-1:0] popcount(input word_t value);
        logic [SBIT_CNT_B-1:0] cnt;
        cnt = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            cnt = cnt + SBIT_CNT_B'(value[i]);
        end
        return cnt;
    endfunction

    ////////////////////
    // Decode
    ////////////////////

    assign is_arith = (instr_i.opcode == VARITH) && (instr_i.funct3 inside {OPIVV, OPIVX, OPIVI})
                      && (instr_i.funct6 inside {VADD, VSUB, VAND, VOR, VXOR});
    assign is_vid   = (instr_i.opcode == VARITH) && (instr_i.funct6 == VID)
                      && (instr_i.funct3 == OPMVV);
    assign is_vmv   = (instr_i.opcode == VARITH) && (instr_i.funct6 == VMV_X_S)
                      && (instr_i.funct3 == OPMVV);

    // Element read picks its own slot, index wraps at VLMAX
    assign rd_slot   = is_vmv ? ELEM_B'(scalar_i / LANES) : slot_q;
    assign last_slot = (slot_q == ELEM_B'(ELEMS-1));
    assign ready_o   = !busy_q;
    assign elem_o    = vs2_data;

    ////////////////////
    // Execute
    ////////////////////

    assign op_b    = (instr_i.funct3 == OPIVV) ? vs1_data : scalar_i;
    assign vid_val = word_t'(slot_q) * word_t'(LANES) + word_t'(LANE_ID);

    always_comb begin
        case (instr_i.funct6)
            VADD:    alu_res = vs2_data + op_b;
            VSUB:    alu_res = vs2_data - op_b;
            VAND:    alu_res = vs2_data & op_b;
            VOR:     alu_res = vs2_data | op_b;
            VXOR:    alu_res = vs2_data ^ op_b;
            default: alu_res = '0;
        endcase
    end

    assign wdata = is_vid ? vid_val : alu_res;
    assign we    = busy_q && (is_arith || is_vid);

    always_ff @(posedge clk_i or negedge resetn_i) begin
        if (!resetn_i) begin
            busy_q     <= 1'b0;
            slot_q     <= '0;
            sbit_cnt_o <= '0;
        end else begin
            if (issue_i) begin
                busy_q <= 1'b1;
                slot_q <= '0;
            end else if (busy_q) begin
                slot_q <= slot_q + 1'b1;
                if (last_slot) begin
                    busy_q <= 1'b0;
                end
            end
            // Count of the final write feeds the balance outputs
            if (we && last_slot) begin
                sbit_cnt_o <= popcount(wdata);
            end
        end
    end

    lane_vrf u_vrf (
        .clk_i     (clk_i),
        .resetn_i  (resetn_i),
        .we_i      (we),
        .waddr_i   (instr_i.vd),
        .raddr_a_i (instr_i.vs1_rs1_imm),
        .raddr_b_i (instr_i.vs2),
        .wslot_i   (slot_q),
        .rslot_i   (rd_slot),
        .wdata_i   (wdata),
        .rdata_a_o (vs1_data),
        .rdata_b_o (vs2_data)
    );

endmodule

//--- src/issue_ctrl.sv
`timescale 1ns/100ps

module issue_ctrl import vc_pkg::*; (
    input  logic             clk_i,
    input  logic             resetn_i,
    input  logic             vreq_i,
    input  logic             iq_full_i,
    input  logic             iq_empty_i,
    input  vinstr_t          iq_instr_i,
    input  word_t            iq_rs1_i,
    input  logic [LANES-1:0] lane_ready_i,
    input  word_t            lane_elem_i [LANES],
    output logic             iq_push_o,
    output logic             iq_pop_o,
    output logic             v_iq_ack_o,
    output logic             v_iq_full_o,
    output logic             issue_o,
    output logic             vready_o,
    output logic             rd_wr_en_o,
    output vinstr_t          instr_o,
    output word_t            scalar_o,
    output word_t            rd_o
);

    logic lanes_ready;
    logic issue;
    logic ready_pending_q;
    logic issue_d_q;
    logic is_vmv;

    ////////////////////
    // Host side
    ////////////////////

    assign iq_push_o   = vreq_i && !iq_full_i;
    assign v_iq_full_o = iq_full_i;

    always_ff @(posedge clk_i or negedge resetn_i) begin
        if (!resetn_i) begin
            v_iq_ack_o <= 1'b0;
        end else begin
            v_iq_ack_o <= iq_push_o;
        end
    end

    ////////////////////
    // Issue
    ////////////////////

    // Lanes run in lock-step, all must be idle
    assign lanes_ready = &lane_ready_i;
    assign vready_o    = lanes_ready;

    // Hold off until the lanes have dropped ready for the last issue
    assign issue    = !iq_empty_i && lanes_ready && !ready_pending_q;
    assign iq_pop_o = issue;
    assign issue_o  = issue;

    always_ff @(posedge clk_i or negedge resetn_i) begin
        if (!resetn_i) begin
            ready_pending_q <= 1'b0;
            issue_d_q       <= 1'b0;
            instr_o         <= '0;
            scalar_o        <= '0;
        end else begin
            issue_d_q <= issue;
            if (issue) begin
                ready_pending_q <= 1'b1;
            end else if (!lanes_ready) begin
                ready_pending_q <= 1'b0;
            end
            if (issue) begin
                instr_o <= iq_instr_i;
                // imm5 is zero-extended
                if (iq_instr_i.funct3 == OPIVI) begin
                    scalar_o <= word_t'(iq_instr_i.vs1_rs1_imm);
                end else begin
                    scalar_o <= iq_rs1_i;
                end
            end
        end
    end

    ////////////////////
    // Scalar result
    ////////////////////

    assign is_vmv = (instr_o.opcode == VARITH) && (instr_o.funct6 == VMV_X_S)
                    && (instr_o.funct3 == OPMVV);

    // Owning lane is the element index modulo LANES
    always_ff @(posedge clk_i or negedge resetn_i) begin
        if (!resetn_i) begin
            rd_wr_en_o <= 1'b0;
            rd_o       <= '0;
        end else begin
            rd_wr_en_o <= issue_d_q && is_vmv;
            if (issue_d_q && is_vmv) begin
                rd_o <= lane_elem_i[scalar_o[LANE_B-1:0]];
            end
        end
    end

endmodule

//--- src/balance_ctrl.sv
`timescale 1ns/100ps

module balance_ctrl import vc_pkg::*; (
    input  logic [SBIT_CNT_B-1:0] lane_sbit_cnt_i [LANES],
    output logic [SBIT_CNT_B-1:0] balance_cnt_o   [LANES-1]
);

    // Entry k compares lane k against lane k+1
    for (genvar k = 0; k < LANES-1; k++) begin : g_diff
        logic [SBIT_CNT_B-1:0] cnt_lo;
        logic [SBIT_CNT_B-1:0] cnt_hi;

        assign cnt_lo = lane_sbit_cnt_i[k];
        assign cnt_hi = lane_sbit_cnt_i[k+1];

        assign balance_cnt_o[k] = (cnt_lo >= cnt_hi) ? (cnt_lo - cnt_hi)
                                                     : (cnt_hi - cnt_lo);
    end

endmodule

//--- src/vector_core.sv
`timescale 1ns/100ps

module vector_core import vc_pkg::*; (
    input  logic                  clk_i,
    input  logic                  resetn_i,
    input  logic                  vreq_i,
    input  word_t                 vinstr_i,
    input  word_t                 rs1_i,
    output logic                  vready_o,
    output logic                  v_iq_ack_o,
    output logic                  v_iq_full_o,
    output logic                  rd_wr_en_o,
    output word_t                 rd_o,
    output logic [SBIT_CNT_B-1:0] sbit_cnt_o [LANES-1]
);

    logic                  iq_push;
    logic                  iq_pop;
    logic                  iq_full;
    logic                  iq_empty;
    vinstr_t               iq_instr;
    word_t                 iq_rs1;
    logic                  issue;
    vinstr_t               instr_run;
    word_t                 scalar;
    logic [LANES-1:0]      lane_ready;
    word_t                 lane_elem     [LANES];
    logic [SBIT_CNT_B-1:0] lane_sbit_cnt [LANES];

    ////////////////////
    // Queues
    ////////////////////

    vc_fifo #(.T(vinstr_t)) u_iq (
        .clk_i    (clk_i),
        .resetn_i (resetn_i),
        .push_i   (iq_push),
        .pop_i    (iq_pop),
        .data_i   (vinstr_t'(vinstr_i)),
        .data_o   (iq_instr),
        .empty_o  (iq_empty),
        .full_o   (iq_full)
    );

    // Moves in step with the instruction queue, flags not needed
    vc_fifo #(.T(word_t)) u_rs1q (
        .clk_i    (clk_i),
        .resetn_i (resetn_i),
        .push_i   (iq_push),
        .pop_i    (iq_pop),
        .data_i   (rs1_i),
        .data_o   (iq_rs1),
        .empty_o  (),
        .full_o   ()
    );

    issue_ctrl u_issue (
        .clk_i        (clk_i),
        .resetn_i     (resetn_i),
        .vreq_i       (vreq_i),
        .iq_full_i    (iq_full),
        .iq_empty_i   (iq_empty),
        .iq_instr_i   (iq_instr),
        .iq_rs1_i     (iq_rs1),
        .lane_ready_i (lane_ready),
        .lane_elem_i  (lane_elem),
        .iq_push_o    (iq_push),
        .iq_pop_o     (iq_pop),
        .v_iq_ack_o   (v_iq_ack_o),
        .v_iq_full_o  (v_iq_full_o),
        .issue_o      (issue),
        .vready_o     (vready_o),
        .rd_wr_en_o   (rd_wr_en_o),
        .instr_o      (instr_run),
        .scalar_o     (scalar),
        .rd_o         (rd_o)
    );

    ////////////////////
    // Lanes
    ////////////////////

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        lane #(.LANE_ID(i)) u_lane (
            .clk_i      (clk_i),
            .resetn_i   (resetn_i),
            .issue_i    (issue),
            .instr_i    (instr_run),
            .scalar_i   (scalar),
            .ready_o    (lane_ready[i]),
            .elem_o     (lane_elem[i]),
            .sbit_cnt_o (lane_sbit_cnt[i])
        );
    end

    balance_ctrl u_balance (
        .lane_sbit_cnt_i (lane_sbit_cnt),
        .balance_cnt_o   (sbit_cnt_o)
    );

endmodule

//--- verif/vector_core_chk.sv
`timescale 1ns/100ps

module vector_core_chk (
    input logic clk_i,
    input logic resetn_i,
    input logic vreq_i,
    input logic ack_i,
    input logic full_i,
    input logic rd_wr_en_i
);

    // Acknowledge only follows a request on the previous edge
    ack_after_req: assert property (@(posedge clk_i) disable iff (!resetn_i)
                                    ack_i |-> $past(vreq_i))
        else $error("Acknowledge without a request on the previous edge");

    // Accepting edge must have seen a queue with room
    ack_not_full: assert property (@(posedge clk_i) disable iff (!resetn_i)
                                   ack_i |-> !$past(full_i))
        else $error("Acknowledge for a request that met a full queue");

    // Scalar result strobe is a single pulse
    rd_strobe_pulse: assert property (@(posedge clk_i) disable iff (!resetn_i)
                                      rd_wr_en_i |=> !rd_wr_en_i)
        else $error("rd_wr_en_o stayed high for more than one cycle");

endmodule

bind vector_core vector_core_chk u_chk (
    .clk_i      (clk_i),
    .resetn_i   (resetn_i),
    .vreq_i     (vreq_i),
    .ack_i      (v_iq_ack_o),
    .full_i     (v_iq_full_o),
    .rd_wr_en_i (rd_wr_en_o)
);

//--- verif/vector_core_tb.sv
`timescale 1ns/100ps

module vector_core_tb import vc_pkg::*; ();

    localparam int STEP_LIMIT  = 400;
    localparam int IDLE_CYCLES = 3;

    logic                  clk_i;
    logic                  resetn_i;
    logic                  vreq_i;
    word_t                 vinstr_i;
    word_t                 rs1_i;
    logic                  vready_o;
    logic                  v_iq_ack_o;
    logic                  v_iq_full_o;
    logic                  rd_wr_en_o;
    word_t                 rd_o;
    logic [SBIT_CNT_B-1:0] sbit_cnt_o [LANES-1];

    word_t exp_q [$];
    word_t res_q [$];
    int    errors;
    int    test_num;
    logic  aborted;
    logic  full_seen;
    logic  blocked_seen;

    vector_core dut0 (
        .clk_i       (clk_i),
        .resetn_i    (resetn_i),
        .vreq_i      (vreq_i),
        .vinstr_i    (vinstr_i),
        .rs1_i       (rs1_i),
        .vready_o    (vready_o),
        .v_iq_ack_o  (v_iq_ack_o),
        .v_iq_full_o (v_iq_full_o),
        .rd_wr_en_o  (rd_wr_en_o),
        .rd_o        (rd_o),
        .sbit_cnt_o  (sbit_cnt_o)
    );

    always #10 clk_i = ~clk_i;

    // Outputs only move on the rising edge
    always @(negedge clk_i) begin
        if (rd_wr_en_o) begin
            res_q.push_back(rd_o);
        end
        if (v_iq_full_o) begin
            full_seen = 1'b1;
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    function automatic word_t encode(input logic [5:0] funct6, input logic [4:0] vs2,
                                     input logic [4:0] vs1, input logic [2:0] funct3,
                                     input logic [4:0] vd);
        return {funct6, 1'b1, vs2, vs1, funct3, vd, VARITH};
    endfunction

    // Request stays up until the queue acknowledges it
    task automatic push_instr(input word_t instr, input word_t rs1);
        int waited;
        waited   = 0;
        vreq_i   = 1'b1;
        vinstr_i = instr;
        rs1_i    = rs1;
        @(negedge clk_i);
        while (!v_iq_ack_o) begin
            // No ack here means the last edge refused the entry
            blocked_seen = 1'b1;
            if (waited == STEP_LIMIT) begin
                $display("Timeout: request for instruction %h was never acknowledged", instr);
                aborted = 1'b1;
                vreq_i  = 1'b0;
                return;
            end
            waited++;
            @(negedge clk_i);
        end
        vreq_i = 1'b0;
    endtask

    // Ready held for a few cycles means the queue has drained
    task automatic wait_idle();
        int waited;
        int high;
        waited = 0;
        high   = 0;
        while (high < IDLE_CYCLES) begin
            if (waited == STEP_LIMIT) begin
                $display("Timeout: the vector core never returned to idle");
                aborted = 1'b1;
                return;
            end
            @(negedge clk_i);
            waited++;
            high = vready_o ? high + 1 : 0;
        end
    endtask

    task automatic check_reads(inout int fails);
        word_t got;
        word_t want;
        assert (res_q.size() == exp_q.size()) else begin
            $display("Got %0d scalar results where %0d were expected",
                     res_q.size(), exp_q.size());
            fails++;
        end
        while (exp_q.size() > 0 && res_q.size() > 0) begin
            want = exp_q.pop_front();
            got  = res_q.pop_front();
            assert (got == want) else begin
                $display("[FAIL] time %0d ns: rd_o is %h, expected %h", $time, got, want);
                fails++;
            end
        end
        exp_q.delete();
        res_q.delete();
    endtask

    task automatic finish_test(input string name, input int fails);
        test_num++;
        if (fails == 0) begin
            $display("Test %0d, %s: passed", test_num, name);
        end else begin
            $display("Test %0d, %s: %0d checks failed", test_num, name, fails);
        end
        errors += fails;
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic check_reset();
        int fails;
        fails = 0;
        assert (vready_o && !v_iq_full_o && !v_iq_ack_o && !rd_wr_en_o) else begin
            $display("[FAIL] time %0d ns: handshake outputs wrong after reset", $time);
            fails++;
        end
        for (int k = 0; k < LANES-1; k++) begin
            assert (sbit_cnt_o[k] == '0) else begin
                $display("[FAIL] time %0d ns: sbit_cnt_o[%0d] is %0d after reset",
                         $time, k, sbit_cnt_o[k]);
                fails++;
            end
        end
        finish_test("reset state", fails);
    endtask

    // Every index of v1, then the same indices offset by VLMAX
    task automatic check_vid_read();
        int fails;
        fails = 0;
        push_instr(encode(VID, 5'd0, 5'd0, OPMVV, 5'd1), '0);
        for (int i = 0; i < 2*VLMAX && !aborted; i++) begin
            push_instr(encode(VMV_X_S, 5'd1, 5'd0, OPMVV, 5'd0), word_t'(i));
            exp_q.push_back(word_t'(i % VLMAX));
        end
        if (!aborted) begin
            wait_idle();
        end
        if (aborted) begin
            return;
        end
        check_reads(fails);
        finish_test("element index write and read with wrap", fails);
    endtask

    task automatic run_golden();
        int         fd;
        int         fails;
        int         n;
        logic [7:0] kind;
        word_t      instr;
        word_t      rs1;
        word_t      want;
        string      skip;
        fd = $fopen("verif/vector_core_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file");
            aborted = 1'b1;
            return;
        end
        fails        = 0;
        full_seen    = 1'b0;
        blocked_seen = 1'b0;
        while (!aborted && $fscanf(fd, " %c", kind) == 1) begin
            if (kind == "#") begin
                n = $fgets(skip, fd);
            end else begin
                n = $fscanf(fd, "%h %h %h", instr, rs1, want);
                if (n != 3) begin
                    $display("A golden line of kind %c is incomplete", kind);
                    aborted = 1'b1;
                end else begin
                    case (kind)
                        "P": push_instr(instr, rs1);
                        "R": begin
                            push_instr(instr, rs1);
                            exp_q.push_back(want);
                        end
                        "E": begin
                            wait_idle();
                            if (!aborted) begin
                                check_reads(fails);
                                finish_test("golden arithmetic read-back", fails);
                                fails = 0;
                            end
                        end
                        "F": begin
                            assert (full_seen && blocked_seen) else begin
                                $display("The queue never filled or no request was held off");
                                fails++;
                            end
                            finish_test("queue full back-pressure", fails);
                            fails        = 0;
                            full_seen    = 1'b0;
                            blocked_seen = 1'b0;
                        end
                        "B": begin
                            wait_idle();
                            if (!aborted) begin
                                check_reads(fails);
                                // Expected differences packed one per byte
                                for (int k = 0; k < LANES-1; k++) begin
                                    assert (sbit_cnt_o[k] == want[8*k +: SBIT_CNT_B]) else begin
                                        $display("[FAIL] time %0d ns: sbit_cnt_o[%0d] is %0d",
                                                 $time, k, sbit_cnt_o[k]);
                                        fails++;
                                    end
                                end
                                finish_test("set-bit balance", fails);
                                fails = 0;
                            end
                        end
                        default: begin
                            $display("Unknown line kind %c in the golden file", kind);
                            aborted = 1'b1;
                        end
                    endcase
                end
            end
        end
        $fclose(fd);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        clk_i        = 1'b0;
        resetn_i     = 1'b0;
        vreq_i       = 1'b0;
        vinstr_i     = '0;
        rs1_i        = '0;
        errors       = 0;
        test_num     = 0;
        aborted      = 1'b0;
        full_seen    = 1'b0;
        blocked_seen = 1'b0;
        repeat (5) @(negedge clk_i);
        resetn_i = 1'b1;
        @(negedge clk_i);
        check_reset();
        check_vid_read();
        if (!aborted) begin
            run_golden();
        end
        $display("Tests run: %0d, failed checks: %0d", test_num, errors);
        if (errors == 0 && !aborted) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- vector_core.f
src/vc_pkg.sv
src/vc_fifo.sv
src/lane_vrf.sv
src/lane.sv
src/issue_ctrl.sv
src/balance_ctrl.sv
src/vector_core.sv
verif/vector_core_chk.sv
verif/vector_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= vector_core_tb
FILELIST  ?= vector_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/vector_core_golden.txt
# kind instr rs1 expected, all values in hex
# P push, R push and expect rd_o, E check reads, F check full, B check reads and balance
P 02108157 00000000 00000000
R 42202057 00000007 0000000e
P 0a2041d7 00000005 00000000
R 42302057 00000011 fffffffd
P 261b3257 ffffffff 00000000
P 2a3202d7 00000000 00000000
R 42502057 00000003 00000003
P 2e104357 a5a5f0f0 00000000
P 02108333 00000000 00000000
R 42602057 0000000c a5a5f0fc
R 42402057 0000000f 00000006
E 00000000 00000000 00000000
F 00000000 00000000 00000000
P 0a104457 0000000d 00000000
R 42802057 0000000c ffffffff
B 00000000 00000000 00000120
